// File: flist.f
+incdir+include
design/llc_geom_pkg.sv
design/llc_entry_pkg.sv
design/llc_wr_if.sv
design/llc_way_ram.sv
design/llc_evict_ram.sv
design/llc_localmem.sv
verification/llc_localmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LLC local memory testbench with Verilator.
# Exits nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=llc_localmem_tb

verilator --binary --timing --assert \
    -f flist.f \
    --top-module "$TOP" \
    --Mdir obj_dir \
    -o llc_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/llc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: include/llc_tb_util.svh
/* testbench helpers: xorshift random source, pass/fail counters and reports */
`ifndef LLC_TB_UTIL_SVH
`define LLC_TB_UTIL_SVH

int unsigned tb_pass_cnt  = 0;
int unsigned tb_fail_cnt  = 0;
int unsigned tb_test_errs = 0;

// 32-bit xorshift, never returns zero for a nonzero seed
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic record_error(input string what);
    tb_test_errs++;
    $display("FAILED at %0t: %s", $time, what);
endtask

// closes the current test and resets its error count
task automatic close_test(input string name);
    if (tb_test_errs == 0) begin
        tb_pass_cnt++;
        $display("test %s: passed", name);
    end else begin
        tb_fail_cnt++;
        $display("test %s: failed with %0d errors", name, tb_test_errs);
    end
    tb_test_errs = 0;
endtask

task automatic print_summary();
    $display("tests passed: %0d, tests failed: %0d", tb_pass_cnt, tb_fail_cnt);
endtask

`endif

// File: verification/llc_localmem_tb.sv
/* LLC local memory testbench: directed and random writes, flushes and reads
   checked every cycle against a reference model of all ways and the evict memory */
`timescale 1ns/1ps

module llc_localmem_tb;

    import llc_entry_pkg::*;

    `include "llc_tb_util.svh"

    localparam int NW          = llc_geom_pkg::LLC_WAYS_DEFAULT;
    localparam int NS          = llc_geom_pkg::LLC_SETS_DEFAULT;
    localparam int RAND_CYCLES = 400;
    // reset, fill, directed tests and random mix
    localparam int RUN_CYCLES  = 10 + NW * NS + 60 + RAND_CYCLES;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * 10;

    typedef logic [NW-1:0] flush_t;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       rd_en;
    logic       wr_en;
    logic       wr_en_evict_way;
    flush_t     wr_rst_flush;
    llc_set_t   set_in;
    llc_way_t   way;
    line_t      wr_data_line;
    llc_tag_t   wr_data_tag;
    sharers_t   wr_data_sharers;
    llc_state_t wr_data_state;
    logic       wr_data_dirty_bit;
    llc_way_t   wr_data_evict_way;

    line_t      rd_data_line      [NW];
    llc_tag_t   rd_data_tag       [NW];
    sharers_t   rd_data_sharers   [NW];
    llc_state_t rd_data_state     [NW];
    logic       rd_data_dirty_bit [NW];
    llc_way_t   rd_data_evict_way;

    // reference model storage and expected read registers
    llc_tag_t   m_tag     [NW][NS];
    line_t      m_line    [NW][NS];
    sharers_t   m_sharers [NW][NS];
    llc_state_t m_state   [NW][NS];
    logic       m_dirty   [NW][NS];
    llc_way_t   m_evict   [NS];
    llc_tag_t   exp_tag     [NW];
    line_t      exp_line    [NW];
    sharers_t   exp_sharers [NW];
    llc_state_t exp_state   [NW];
    logic       exp_dirty   [NW];
    llc_way_t   exp_evict;

    logic [31:0] rng = 32'h554;
    logic        check_en = 1'b0;

    llc_localmem #(
        .NUM_WAYS (NW),
        .NUM_SETS (NS)
    ) llc_localmem_i (
        .clk               (clk),
        .arst_n            (arst_n),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_rst_flush      (wr_rst_flush),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_state     (wr_data_state),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_state     (rd_data_state),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_evict_way (rd_data_evict_way)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // one cycle of stimulus with fresh random write data, driven on the falling edge
    task automatic apply(input logic rd, input logic wr, input logic ev, input flush_t fl,
                         input int set_idx, input int way_idx);
        logic [31:0] r;
        rd_en             = rd;
        wr_en             = wr;
        wr_en_evict_way   = ev;
        wr_rst_flush      = fl;
        set_in            = llc_set_t'(set_idx);
        way               = llc_way_t'(way_idx);
        wr_data_line      = {next_rand(), next_rand()};
        r                 = next_rand();
        wr_data_tag       = llc_tag_t'(r);
        wr_data_sharers   = sharers_t'(r >> 12);
        wr_data_state     = llc_state_t'(r >> 20);
        wr_data_dirty_bit = r[23];
        wr_data_evict_way = llc_way_t'(r >> 24);
        @(negedge clk);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) apply(1'b0, 1'b0, 1'b0, '0, 0, 0);
    endtask

    // model: read-first, then meta and data writes per way
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < NW; w++) begin
                exp_tag[w]     <= '0;
                exp_line[w]    <= '0;
                exp_sharers[w] <= '0;
                exp_state[w]   <= '0;
                exp_dirty[w]   <= 1'b0;
            end
            exp_evict <= '0;
        end else begin
            if (rd_en) begin
                for (int w = 0; w < NW; w++) begin
                    exp_tag[w]     <= m_tag[w][set_in];
                    exp_line[w]    <= m_line[w][set_in];
                    exp_sharers[w] <= m_sharers[w][set_in];
                    exp_state[w]   <= m_state[w][set_in];
                    exp_dirty[w]   <= m_dirty[w][set_in];
                end
                exp_evict <= m_evict[set_in];
            end
            for (int w = 0; w < NW; w++) begin
                if (wr_rst_flush[w] || (wr_en && way == llc_way_t'(w))) begin
                    m_state[w][set_in]   = wr_data_state;
                    m_sharers[w][set_in] = wr_data_sharers;
                    m_dirty[w][set_in]   = wr_data_dirty_bit;
                end
                if (wr_en && (wr_rst_flush[w] || way == llc_way_t'(w))) begin
                    m_tag[w][set_in]  = wr_data_tag;
                    m_line[w][set_in] = wr_data_line;
                end
            end
            if (wr_en_evict_way) begin
                m_evict[set_in] = wr_data_evict_way;
            end
        end
    end

    // outputs and expected values as registered on the previous rising edge
    always @(posedge clk) begin
        if (check_en) begin
            for (int w = 0; w < NW; w++) begin
                assert (rd_data_tag[w] === exp_tag[w])
                    else record_error($sformatf("way %0d tag %h, expected %h",
                                                w, rd_data_tag[w], exp_tag[w]));
                assert (rd_data_line[w] === exp_line[w])
                    else record_error($sformatf("way %0d line %h, expected %h",
                                                w, rd_data_line[w], exp_line[w]));
                assert (rd_data_sharers[w] === exp_sharers[w])
                    else record_error($sformatf("way %0d sharers %h, expected %h",
                                                w, rd_data_sharers[w], exp_sharers[w]));
                assert (rd_data_state[w] === exp_state[w])
                    else record_error($sformatf("way %0d state %h, expected %h",
                                                w, rd_data_state[w], exp_state[w]));
                assert (rd_data_dirty_bit[w] === exp_dirty[w])
                    else record_error($sformatf("way %0d dirty %b, expected %b",
                                                w, rd_data_dirty_bit[w], exp_dirty[w]));
            end
            assert (rd_data_evict_way === exp_evict)
                else record_error($sformatf("evict way %0d, expected %0d",
                                            rd_data_evict_way, exp_evict));
        end
    end

    initial begin
        logic [31:0] r;
        flush_t      fm;
        arst_n            = 1'b0;
        rd_en             = 1'b0;
        wr_en             = 1'b0;
        wr_en_evict_way   = 1'b0;
        wr_rst_flush      = '0;
        set_in            = '0;
        way               = '0;
        wr_data_line      = '0;
        wr_data_tag       = '0;
        wr_data_sharers   = '0;
        wr_data_state     = '0;
        wr_data_dirty_bit = 1'b0;
        wr_data_evict_way = '0;
        repeat (10) @(negedge clk);
        arst_n   = 1'b1;
        check_en = 1'b1;

        idle(3);
        close_test("reset_outputs_zero");

        // memories power up unknown, so every entry gets written first
        for (int s = 0; s < NS; s++) begin
            for (int w = 0; w < NW; w++) begin
                apply(1'b0, 1'b1, w == 0, '0, s, w);
            end
        end
        idle(1);
        close_test("fill");

        apply(1'b0, 1'b1, 1'b0, '0, 5, 2 % NW);
        apply(1'b1, 1'b0, 1'b0, '0, 5, 0);
        idle(2);
        close_test("single_way_write");

        fm = flush_t'(4'b0101);
        apply(1'b0, 1'b0, 1'b0, fm, 9, 0);
        apply(1'b1, 1'b0, 1'b0, '0, 9, 0);
        idle(1);
        apply(1'b0, 1'b1, 1'b0, fm, 9, 1 % NW);
        apply(1'b1, 1'b0, 1'b0, '0, 9, 0);
        idle(2);
        close_test("flush");

        apply(1'b1, 1'b0, 1'b0, '0, 3, 0);
        for (int w = 0; w < NW; w++) begin
            apply(1'b0, 1'b1, 1'b1, '0, 3, w);
        end
        apply(1'b0, 1'b0, 1'b0, fm, 3, 0);
        idle(2);
        // same-set read and write in one cycle
        apply(1'b1, 1'b1, 1'b1, '0, 7, 0);
        apply(1'b1, 1'b0, 1'b0, '0, 7, 0);
        idle(2);
        close_test("hold_and_read_first");

        apply(1'b0, 1'b0, 1'b1, '0, 12, 0);
        apply(1'b1, 1'b0, 1'b0, '0, 12, 0);
        apply(1'b0, 1'b1, 1'b0, fm, 12, 1 % NW);
        apply(1'b1, 1'b0, 1'b0, '0, 12, 0);
        idle(2);
        close_test("evict_way");

        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = next_rand();
            apply(|r[1:0], r[2], r[4:3] == 2'b00,
                  (r[7:5] == 3'b000) ? flush_t'(r >> 8) : '0,
                  int'(r[21:16]) % NS, int'(r[23:22]) % NW);
        end
        idle(2);
        close_test("random_mix");

        print_summary();
        if (tb_fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        print_summary();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: design/llc_localmem.sv
/* LLC local memory: fans the write request out to one RAM per way
   and returns every way's entry plus the set's eviction way */
`timescale 1ns/1ps

module llc_localmem #(
    parameter int NUM_WAYS = llc_geom_pkg::LLC_WAYS_DEFAULT,
    parameter int NUM_SETS = llc_geom_pkg::LLC_SETS_DEFAULT
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      rd_en,
    input  logic                      wr_en,
    input  logic                      wr_en_evict_way,
    input  logic [NUM_WAYS-1:0]       wr_rst_flush,
    input  llc_entry_pkg::llc_set_t   set_in,
    input  llc_entry_pkg::llc_way_t   way,
    input  llc_entry_pkg::line_t      wr_data_line,
    input  llc_entry_pkg::llc_tag_t   wr_data_tag,
    input  llc_entry_pkg::sharers_t   wr_data_sharers,
    input  llc_entry_pkg::llc_state_t wr_data_state,
    input  logic                      wr_data_dirty_bit,
    input  llc_entry_pkg::llc_way_t   wr_data_evict_way,

    output llc_entry_pkg::line_t      rd_data_line      [NUM_WAYS],
    output llc_entry_pkg::llc_tag_t   rd_data_tag       [NUM_WAYS],
    output llc_entry_pkg::sharers_t   rd_data_sharers   [NUM_WAYS],
    output llc_entry_pkg::llc_state_t rd_data_state     [NUM_WAYS],
    output logic                      rd_data_dirty_bit [NUM_WAYS],
    output llc_entry_pkg::llc_way_t   rd_data_evict_way
);

    llc_wr_if wr_req ();

    // one request, seen by every way
    assign wr_req.set_in            = set_in;
    assign wr_req.way               = way;
    assign wr_req.wr_en             = wr_en;
    assign wr_req.wr_data_tag       = wr_data_tag;
    assign wr_req.wr_data_line      = wr_data_line;
    assign wr_req.wr_data_sharers   = wr_data_sharers;
    assign wr_req.wr_data_state     = wr_data_state;
    assign wr_req.wr_data_dirty_bit = wr_data_dirty_bit;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        llc_way_ram #(
            .WAY_ID   (w),
            .NUM_SETS (NUM_SETS)
        ) way_ram_i (
            .clk          (clk),
            .arst_n       (arst_n),
            .rd_en        (rd_en),
            .wr           (wr_req),
            .flush        (wr_rst_flush[w]),
            .rd_tag       (rd_data_tag[w]),
            .rd_line      (rd_data_line[w]),
            .rd_sharers   (rd_data_sharers[w]),
            .rd_state     (rd_data_state[w]),
            .rd_dirty_bit (rd_data_dirty_bit[w])
        );
    end

    // eviction way is written on its own strobe, independent of way writes
    llc_evict_ram #(
        .NUM_SETS (NUM_SETS)
    ) evict_ram_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_en   (rd_en),
        .wr_en   (wr_en_evict_way),
        .set_in  (set_in),
        .wr_data (wr_data_evict_way),
        .rd_data (rd_data_evict_way)
    );

endmodule

// File: design/llc_evict_ram.sv
/* LLC eviction-way memory: next victim way per set, registered read-first read */
`timescale 1ns/1ps

module llc_evict_ram #(
    parameter int NUM_SETS = llc_geom_pkg::LLC_SETS_DEFAULT
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    rd_en,
    input  logic                    wr_en,
    input  llc_entry_pkg::llc_set_t set_in,
    input  llc_entry_pkg::llc_way_t wr_data,
    output llc_entry_pkg::llc_way_t rd_data
);

    import llc_entry_pkg::*;

    llc_way_t evict_mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            evict_mem[set_in] <= wr_data;
        end
    end

    // output holds while rd_en is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= evict_mem[set_in];
        end
    end

endmodule

// File: design/llc_way_ram.sv
/* LLC way storage: tag, line, sharers, state and dirty bit per set,
   with per-way write decode, flush path and a registered read-first port */
`timescale 1ns/1ps

module llc_way_ram #(
    parameter int WAY_ID   = 0,
    parameter int NUM_SETS = llc_geom_pkg::LLC_SETS_DEFAULT
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    rd_en,
    llc_wr_if.sink                  wr,
    input  logic                    flush,
    output llc_entry_pkg::llc_tag_t   rd_tag,
    output llc_entry_pkg::line_t      rd_line,
    output llc_entry_pkg::sharers_t   rd_sharers,
    output llc_entry_pkg::llc_state_t rd_state,
    output logic                    rd_dirty_bit
);

    import llc_entry_pkg::*;

    llc_tag_t   tag_mem     [NUM_SETS];
    line_t      line_mem    [NUM_SETS];
    sharers_t   sharers_mem [NUM_SETS];
    llc_state_t state_mem   [NUM_SETS];
    logic       dirty_mem   [NUM_SETS];

    logic way_hit;
    logic meta_en;
    logic data_en;

    assign way_hit = (wr.way == llc_way_t'(WAY_ID));

    // flush always rewrites the meta fields of this way
    assign meta_en = flush | (wr.wr_en & way_hit);
    // tag and line need wr_en even during a flush
    assign data_en = wr.wr_en & (flush | way_hit);

    always_ff @(posedge clk) begin
        if (meta_en) begin
            state_mem[wr.set_in]   <= wr.wr_data_state;
            sharers_mem[wr.set_in] <= wr.wr_data_sharers;
            dirty_mem[wr.set_in]   <= wr.wr_data_dirty_bit;
        end
        if (data_en) begin
            tag_mem[wr.set_in]  <= wr.wr_data_tag;
            line_mem[wr.set_in] <= wr.wr_data_line;
        end
    end

    // read-first, the write above lands after this sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_tag       <= '0;
            rd_line      <= '0;
            rd_sharers   <= '0;
            rd_state     <= '0;
            rd_dirty_bit <= 1'b0;
        end else if (rd_en) begin
            rd_tag       <= tag_mem[wr.set_in];
            rd_line      <= line_mem[wr.set_in];
            rd_sharers   <= sharers_mem[wr.set_in];
            rd_state     <= state_mem[wr.set_in];
            rd_dirty_bit <= dirty_mem[wr.set_in];
        end
    end

endmodule

// File: design/llc_wr_if.sv
/* LLC write request shared by all ways: set, way select and the entry fields */
`timescale 1ns/1ps

interface llc_wr_if;

    import llc_entry_pkg::*;

    llc_set_t   set_in;
    llc_way_t   way;
    logic       wr_en;
    llc_tag_t   wr_data_tag;
    line_t      wr_data_line;
    sharers_t   wr_data_sharers;
    llc_state_t wr_data_state;
    logic       wr_data_dirty_bit;

    modport source (
        output set_in, way, wr_en,
        output wr_data_tag, wr_data_line, wr_data_sharers,
        output wr_data_state, wr_data_dirty_bit
    );

    // set_in doubles as the read index on the way side
    modport sink (
        input set_in, way, wr_en,
        input wr_data_tag, wr_data_line, wr_data_sharers,
        input wr_data_state, wr_data_dirty_bit
    );

endinterface

// File: design/llc_entry_pkg.sv
/* LLC entry fields: vector types for the index and the stored per-way fields */
package llc_entry_pkg;

    import llc_geom_pkg::*;

    localparam int LLC_TAG_BITS     = 12;
    localparam int LLC_LINE_BITS    = 64;
    localparam int LLC_SHARERS_BITS = 8;
    localparam int LLC_STATE_BITS   = 3;

    // indices
    typedef logic [LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;

    // stored fields
    typedef logic [LLC_TAG_BITS-1:0]     llc_tag_t;
    typedef logic [LLC_LINE_BITS-1:0]    line_t;
    typedef logic [LLC_SHARERS_BITS-1:0] sharers_t;

    // coherence state code, encoding owned by the controller
    typedef logic [LLC_STATE_BITS-1:0] llc_state_t;

endpackage

// File: design/llc_geom_pkg.sv
/* LLC geometry: way and set index widths plus the default cache shape */
package llc_geom_pkg;

    // index widths sized for the largest supported cache
    localparam int LLC_WAY_BITS = 2;
    localparam int LLC_SET_BITS = 6;

    // largest shape the index widths can address
    localparam int LLC_WAYS_MAX = 1 << LLC_WAY_BITS;
    localparam int LLC_SETS_MAX = 1 << LLC_SET_BITS;

    // default shape used by the top level
    localparam int LLC_WAYS_DEFAULT = LLC_WAYS_MAX;
    localparam int LLC_SETS_DEFAULT = LLC_SETS_MAX;

endpackage
